// File: project.f
src/cpc_bus_pkg.sv
src/rom_image_pkg.sv
src/rom_loader.sv
src/mf2_control.sv
src/mf2_shadow_decode.sv
src/mf2_ram.sv
src/cpc_expansion_top.sv
tb/cpc_expansion_checker.sv
tb/cpc_expansion_tb.sv

// File: Makefile
SIM = obj_dir/Vcpc_expansion_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): project.f src/*.sv tb/*.sv
	verilator --binary --assert -j 0 --top-module cpc_expansion_tb -f project.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/cpc_expansion_tb.sv
module cpc_expansion_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int K_LOAD = 0;
	localparam int K_NOLOAD = 1;
	localparam int K_KEY = 2;
	localparam int K_FETCH = 3;
	localparam int K_SEL = 4;
	localparam int K_IOWR = 5;
	localparam int K_RAMWR = 6;
	localparam int K_RAMRD = 7;
	localparam int TABLE_LEN = 30;

	typedef struct {
		int          kind;
		logic [24:0] addr;
		logic [7:0]  index;
		logic [7:0]  data;
		logic [15:0] ext;
		logic [23:0] expect_val;
		int          count;
		logic [1:0]  bank;
	} step_t;

	logic                       clk_sys = 1'b0;
	logic                       reset;
	rom_image_pkg::download_t   dl;
	logic                       key_nmi;
	cpc_bus_pkg::cpu_bus_t      bus;
	cpc_bus_pkg::mf2_cfg_t      cfg;
	rom_image_pkg::boot_write_t boot;
	logic                       download_wait;
	rom_image_pkg::rom_map_t    rom_map;
	logic                       nmi;
	logic                       mf2_rom_sel;
	logic                       mf2_ram_sel;
	cpc_bus_pkg::cpu_data_t     mf2_data;

	step_t                  steps [$];
	rom_image_pkg::rom_map_t exp_map;
	cpc_bus_pkg::cpu_data_t ram_model [int];

	cpc_expansion_top cpc_expansion_top_inst (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .key_nmi(key_nmi), .bus(bus), .cfg(cfg),
		.boot(boot), .download_wait(download_wait), .rom_map(rom_map), .nmi(nmi),
		.mf2_rom_sel(mf2_rom_sel), .mf2_ram_sel(mf2_ram_sel), .mf2_data(mf2_data)
	);

	always #20 clk_sys = ~clk_sys;

	// Watchdog sized on the table length
	initial begin
		#((TABLE_LEN * 40 + 16) * 40);
		$display("Timeout: the test table did not finish in time");
		$display("Errors found");
		$fatal(1);
	end

	//////////////////////////////////////////////////
	// Compare tasks

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_boot(input rom_image_pkg::boot_write_t got,
			input rom_image_pkg::boot_write_t exp);
		if (got !== exp) begin
			stop_run($sformatf("** Error at %0t: boot = %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic check_data(input cpc_bus_pkg::cpu_data_t got,
			input cpc_bus_pkg::cpu_data_t exp);
		if (got !== exp) begin
			stop_run($sformatf("** Error at %0t: mf2_data = %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic check_map(input rom_image_pkg::rom_map_t got,
			input rom_image_pkg::rom_map_t exp);
		if (got !== exp) begin
			stop_run($sformatf("** Error at %0t: rom_map = %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic wait_level(input logic want, input string what);
		int n;
		n = 0;
		while (((what == "wait") ? download_wait : boot.wr) !== want) begin
			@(negedge clk_sys);
			n++;
			if (n > 60) begin
				stop_run($sformatf("Timed out waiting for %s to become %b", what, want));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Step drivers

	task automatic load_rom_byte(input step_t s);
		rom_image_pkg::boot_write_t exp;
		dl.index = s.index;
		dl.addr = s.addr;
		dl.data = s.data;
		dl.ext = s.ext;
		dl.active = 1'b1;
		@(negedge clk_sys);
		dl.wr = 1'b1;
		@(negedge clk_sys);
		wait_level(1'b1, "wait");
		dl.wr = 1'b0;
		for (int b = 0; b < s.count; b++) begin
			wait_level(1'b1, "wr");
			exp = '{wr: 1'b1, addr: s.expect_val[22:0], bank: (b == 0) ? s.bank : 2'd1,
				data: s.data};
			check_boot(boot, exp);
			if (s.expect_val[22]) begin
				exp_map[s.expect_val[21:14]] = 1'b1;
			end
			wait_level(1'b0, "wr");
		end
		// Wait drops together with the last strobe
		check_bit("download_wait", download_wait, 1'b0);
		dl.active = 1'b0;
		@(negedge clk_sys);
		check_map(rom_map, exp_map);
	endtask

	task automatic send_rejected_byte(input step_t s);
		dl.index = s.index;
		dl.addr = s.addr;
		dl.active = 1'b1;
		@(negedge clk_sys);
		dl.wr = 1'b1;
		repeat (12) begin
			@(negedge clk_sys);
			check_bit("download_wait", download_wait, 1'b0);
			check_bit("boot.wr", boot.wr, 1'b0);
		end
		dl.wr = 1'b0;
		dl.active = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic drive_bus_step(input step_t s);
		cpc_bus_pkg::cpu_data_t value;
		bus.addr = s.addr[15:0];
		case (s.kind)
			K_KEY: key_nmi = 1'b1;
			K_FETCH: bus.m1 = 1'b1;
			K_IOWR: begin
				bus.dout = s.data;
				bus.iorq = 1'b1;
				bus.wr = 1'b1;
			end
			K_RAMWR: begin
				value = 8'($urandom);
				ram_model[s.addr[12:0]] = value;
				bus.dout = value;
				bus.mem_wr = 1'b1;
			end
			K_RAMRD: bus.mem_rd = s.count[0];
			default: ;
		endcase
		@(negedge clk_sys);
		key_nmi = 1'b0;
		bus.m1 = 1'b0;
		bus.iorq = 1'b0;
		bus.wr = 1'b0;
		bus.mem_wr = 1'b0;
		if (s.kind == K_KEY || s.kind == K_FETCH) begin
			check_bit("nmi", nmi, s.expect_val[0]);
		end else if (s.kind == K_SEL) begin
			check_bit("mf2_rom_sel", mf2_rom_sel, s.expect_val[0]);
		end else if (s.kind == K_RAMRD) begin
			@(negedge clk_sys);
			// Bit 9 is the expected RAM window select
			check_bit("mf2_ram_sel", mf2_ram_sel, s.expect_val[9]);
			// Bit 8 picks the byte written earlier with a random value
			value = s.expect_val[8] ? ram_model[s.addr[12:0]] : s.expect_val[7:0];
			check_data(mf2_data, value);
			bus.mem_rd = 1'b0;
		end
		repeat (2) @(negedge clk_sys);
	endtask

	function automatic step_t make_step(input int kind, input logic [24:0] addr,
			input logic [7:0] index, input logic [7:0] data, input logic [15:0] ext,
			input logic [23:0] expect_val, input int count, input logic [1:0] bank);
		step_t s;
		s = '{kind, addr, index, data, ext, expect_val, count, bank};
		return s;
	endfunction

	//////////////////////////////////////////////////
	// Table and main sequence

	initial begin
		void'($urandom(32'hf39484a2));
		reset = 1'b1;
		dl = '0;
		key_nmi = 1'b0;
		bus = '0;
		cfg = '0;
		exp_map = '0;

		// System ROM slices and expansion pages
		steps.push_back(make_step(K_LOAD, 25'h04123, 8'd0, 8'hA5, "ZZ", 24'h400123, 1, 2'd0));
		steps.push_back(make_step(K_LOAD, 25'h18045, 8'd0, 8'h5A, "ZZ", 24'h41C045, 1, 2'd1));
		steps.push_back(make_step(K_LOAD, 25'h00010, 8'd1, 8'h3C, "3A", 24'h4E8010, 2, 2'd0));
		steps.push_back(make_step(K_LOAD, 25'h00005, 8'd1, 8'hC3, "Q7", 24'h7B8005, 2, 2'd0));
		steps.push_back(make_step(K_NOLOAD, 25'h24000, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		// NMI and paging
		steps.push_back(make_step(K_KEY, 25'h0000, 8'd0, 8'h00, "ZZ", 24'h1, 0, 2'd0));
		steps.push_back(make_step(K_FETCH, 25'h0066, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_SEL, 25'h0100, 8'd0, 8'h00, "ZZ", 24'h1, 0, 2'd0));
		steps.push_back(make_step(K_KEY, 25'h0000, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_IOWR, 25'hFEEA, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_SEL, 25'h0100, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_IOWR, 25'hFEE8, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_SEL, 25'h0100, 8'd0, 8'h00, "ZZ", 24'h1, 0, 2'd0));
		// RAM window with random bytes
		steps.push_back(make_step(K_RAMWR, 25'h2000, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_RAMWR, 25'h2ABC, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_RAMWR, 25'h3FFE, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_RAMRD, 25'h2000, 8'd0, 8'h00, "ZZ", 24'h300, 1, 2'd0));
		steps.push_back(make_step(K_RAMRD, 25'h2ABC, 8'd0, 8'h00, "ZZ", 24'h300, 1, 2'd0));
		steps.push_back(make_step(K_RAMRD, 25'h3FFE, 8'd0, 8'h00, "ZZ", 24'h300, 1, 2'd0));
		steps.push_back(make_step(K_RAMRD, 25'h2000, 8'd0, 8'h00, "ZZ", 24'h2FF, 0, 2'd0));
		steps.push_back(make_step(K_RAMRD, 25'h4000, 8'd0, 8'h00, "ZZ", 24'hFF, 1, 2'd0));
		// Register shadowing, pen 3 and CRTC register 12
		steps.push_back(make_step(K_IOWR, 25'h7F00, 8'd0, 8'h03, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_IOWR, 25'h7F00, 8'd0, 8'h55, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_IOWR, 25'hBC00, 8'd0, 8'h0C, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_IOWR, 25'hBD00, 8'd0, 8'h30, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_RAMRD, 25'h3F93, 8'd0, 8'h00, "ZZ", 24'h255, 1, 2'd0));
		steps.push_back(make_step(K_RAMRD, 25'h3DBC, 8'd0, 8'h00, "ZZ", 24'h230, 1, 2'd0));
		// Hide at the return address
		steps.push_back(make_step(K_FETCH, 25'h0065, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_IOWR, 25'hFEE8, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));
		steps.push_back(make_step(K_SEL, 25'h0100, 8'd0, 8'h00, "ZZ", 24'h0, 0, 2'd0));

		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		foreach (steps[i]) begin
			if (steps[i].kind == K_LOAD) begin
				load_rom_byte(steps[i]);
			end else if (steps[i].kind == K_NOLOAD) begin
				send_rejected_byte(steps[i]);
			end else begin
				drive_bus_step(steps[i]);
			end
		end

		$display("No errors");
		$finish;
	end

endmodule

// File: tb/cpc_expansion_checker.sv
module cpc_expansion_checker (
	input logic clk_sys,
	input logic reset,
	input logic nmi,
	input logic enabled,
	input logic boot_wr,
	input logic download_wait
);

	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////
	// NMI and boot strobe properties

	a_nmi_idle: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> !$past(enabled)) else $error("nmi rose while the page was enabled");

	// Strobe spans one reference period
	a_wr_len: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(boot_wr) |-> boot_wr[*8] ##1 !boot_wr)
		else $error("boot wr pulse is not 8 cycles long");

	a_wr_wait: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr |-> download_wait) else $error("boot wr high without download_wait");

endmodule

bind mf2_control cpc_expansion_checker mf2_checker_inst (.clk_sys(clk_sys), .reset(reset),
	.nmi(nmi), .enabled(enabled), .boot_wr(1'b0), .download_wait(1'b0));

bind rom_loader cpc_expansion_checker loader_checker_inst (.clk_sys(clk_sys), .reset(reset),
	.nmi(1'b0), .enabled(1'b0), .boot_wr(boot_wr), .download_wait(download_wait));

// File: src/cpc_expansion_top.sv
module cpc_expansion_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  rom_image_pkg::download_t   dl,
	input  logic                       key_nmi,
	input  cpc_bus_pkg::cpu_bus_t      bus,
	input  cpc_bus_pkg::mf2_cfg_t      cfg,
	output rom_image_pkg::boot_write_t boot,
	output logic                       download_wait,
	output rom_image_pkg::rom_map_t    rom_map,
	output logic                       nmi,
	output logic                       mf2_rom_sel,
	output logic                       mf2_ram_sel,
	output cpc_bus_pkg::cpu_data_t     mf2_data
);

	logic                   io_write_edge;
	logic                   shadow_wr;
	cpc_bus_pkg::mf2_addr_t shadow_addr;

	//////////////////////////////////////////////////
	// ROM image loader

	rom_loader rom_loader_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl),
		.boot          (boot),
		.download_wait (download_wait),
		.rom_map       (rom_map)
	);

	//////////////////////////////////////////////////
	// Multiface Two

	mf2_control mf2_control_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus           (bus),
		.key_nmi       (key_nmi),
		.cfg           (cfg),
		.nmi           (nmi),
		.rom_sel       (mf2_rom_sel),
		.ram_sel       (mf2_ram_sel),
		.io_write_edge (io_write_edge)
	);

	mf2_shadow_decode mf2_shadow_decode_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus           (bus),
		.io_write_edge (io_write_edge),
		.shadow_wr     (shadow_wr),
		.shadow_addr   (shadow_addr)
	);

	mf2_ram mf2_ram_inst (
		.clk_sys     (clk_sys),
		.bus         (bus),
		.ram_sel     (mf2_ram_sel),
		.shadow_wr   (shadow_wr),
		.shadow_addr (shadow_addr),
		.data        (mf2_data)
	);

endmodule

// File: src/mf2_ram.sv
module mf2_ram (
	input  logic                   clk_sys,
	input  cpc_bus_pkg::cpu_bus_t  bus,
	input  logic                   ram_sel,
	input  logic                   shadow_wr,
	input  cpc_bus_pkg::mf2_addr_t shadow_addr,
	output cpc_bus_pkg::cpu_data_t data
);

	cpc_bus_pkg::cpu_data_t mem [0:(1 << $bits(cpc_bus_pkg::mf2_addr_t)) - 1];

	cpc_bus_pkg::mf2_addr_t ram_addr;
	cpc_bus_pkg::cpu_data_t ram_din;
	cpc_bus_pkg::cpu_data_t ram_q;
	logic                   ram_we;

	//////////////////////////////////////////////////
	// Address and write mux

	always_ff @(posedge clk_sys) begin
		if (shadow_wr) begin
			// Hardware register shadow has priority
			ram_addr <= shadow_addr;
			ram_din <= bus.dout;
			ram_we <= 1'b1;
		end else if (bus.mem_wr && ram_sel) begin
			ram_addr <= bus.addr[12:0];
			ram_din <= bus.dout;
			ram_we <= 1'b1;
		end else begin
			ram_addr <= bus.addr[12:0];
			ram_we <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// 8K array

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_din;
			ram_q <= ram_din;
		end else begin
			ram_q <= mem[ram_addr];
		end
	end

	// Idle bus reads as FFh
	assign data = (ram_sel & bus.mem_rd) ? ram_q : 8'hFF;

endmodule

// File: src/mf2_shadow_decode.sv
module mf2_shadow_decode (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cpc_bus_pkg::cpu_bus_t  bus,
	input  logic                   io_write_edge,
	output logic                   shadow_wr,
	output cpc_bus_pkg::mf2_addr_t shadow_addr
);

	logic [7:0] port_hi;
	logic [4:0] pen_index;
	logic [3:0] crtc_reg;

	assign port_hi = bus.addr[15:8];

	//////////////////////////////////////////////////
	// Port to shadow address

	always_comb begin
		shadow_addr = '0;
		case (port_hi)
			cpc_bus_pkg::GA_PORT_HI: begin
				// Gate array function in data bits 7..6
				case (bus.dout[7:6])
					2'b00: shadow_addr = cpc_bus_pkg::SHADOW_PEN_INDEX;
					2'b01: begin
						if (pen_index[4]) begin
							shadow_addr = cpc_bus_pkg::SHADOW_BORDER;
						end else begin
							shadow_addr = cpc_bus_pkg::SHADOW_PEN_BASE +
								cpc_bus_pkg::mf2_addr_t'(pen_index[3:0]);
						end
					end
					2'b10:   shadow_addr = cpc_bus_pkg::SHADOW_MODE;
					default: shadow_addr = cpc_bus_pkg::SHADOW_BANKING;
				endcase
			end
			cpc_bus_pkg::CRTC_SEL_HI: shadow_addr = cpc_bus_pkg::SHADOW_CRTC_SEL;
			cpc_bus_pkg::CRTC_DATA_HI: begin
				shadow_addr = cpc_bus_pkg::SHADOW_CRTC_BASE +
					cpc_bus_pkg::mf2_addr_t'(crtc_reg);
			end
			cpc_bus_pkg::PPI_CTRL_HI: shadow_addr = cpc_bus_pkg::SHADOW_PPI;
			cpc_bus_pkg::ROM_SEL_HI:  shadow_addr = cpc_bus_pkg::SHADOW_ROM_SEL;
			default:                  shadow_addr = '0;
		endcase
	end

	// Address 0 means the port is not shadowed
	assign shadow_wr = io_write_edge & (shadow_addr != '0);

	//////////////////////////////////////////////////
	// Pen and CRTC register tracking

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg <= '0;
		end else if (io_write_edge) begin
			if (port_hi == cpc_bus_pkg::GA_PORT_HI && bus.dout[7:6] == 2'b00) begin
				pen_index <= bus.dout[4:0];
			end
			if (port_hi == cpc_bus_pkg::CRTC_SEL_HI) begin
				crtc_reg <= bus.dout[3:0];
			end
		end
	end

endmodule

// File: src/mf2_control.sv
module mf2_control (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cpc_bus_pkg::cpu_bus_t bus,
	input  logic                  key_nmi,
	input  cpc_bus_pkg::mf2_cfg_t cfg,
	output logic                  nmi,
	output logic                  rom_sel,
	output logic                  ram_sel,
	output logic                  io_write_edge
);

	logic key_q;
	logic m1_q;
	logic io_wr_q;

	logic io_wr;
	logic key_rise;
	logic m1_rise;
	logic io_rise;
	logic port_hit;

	logic enabled;
	logic hidden;

	//////////////////////////////////////////////////
	// Edge detection

	assign io_wr = bus.wr & bus.iorq;
	assign key_rise = key_nmi & ~key_q;
	assign m1_rise = bus.m1 & ~m1_q;
	assign io_rise = io_wr & ~io_wr_q;

	// FEE8 enables, FEEA disables
	assign port_hit = (bus.addr[15:2] == cpc_bus_pkg::MF2_PORT_BASE);

	// Own port writes are not shadowed
	assign io_write_edge = io_rise & ~port_hit;

	//////////////////////////////////////////////////
	// NMI, enable and hide

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_q <= 1'b0;
			m1_q <= 1'b0;
			io_wr_q <= 1'b0;
			nmi <= 1'b0;
			enabled <= 1'b0;
			hidden <= cfg.hidden_at_reset;
		end else begin
			key_q <= key_nmi;
			m1_q <= bus.m1;
			io_wr_q <= io_wr;

			if (key_rise && !enabled && !cfg.disabled) begin
				nmi <= 1'b1;
			end
			// Page comes in on the NMI vector fetch
			if (nmi && m1_rise && (bus.addr == cpc_bus_pkg::MF2_NMI_VECTOR)) begin
				enabled <= 1'b1;
				hidden <= 1'b0;
				nmi <= 1'b0;
			end
			if (enabled && m1_rise && (bus.addr == cpc_bus_pkg::MF2_RET_ADDR)) begin
				hidden <= 1'b1;
			end
			if (io_rise && port_hit) begin
				enabled <= ~bus.addr[1] & ~hidden & ~cfg.disabled;
			end
		end
	end

	// ROM at 0000-1FFF and RAM at 2000-3FFF
	assign rom_sel = enabled & (bus.addr[15:13] == 3'b000);
	assign ram_sel = enabled & (bus.addr[15:13] == 3'b001);

endmodule

// File: src/rom_loader.sv
module rom_loader (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  rom_image_pkg::download_t   dl,
	output rom_image_pkg::boot_write_t boot,
	output logic                       download_wait,
	output rom_image_pkg::rom_map_t    rom_map
);

	// Returns {valid, value} for one ASCII hex digit
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9") begin
			r = {1'b1, c[3:0]};
		end else if (c >= "A" && c <= "F") begin
			r = {1'b1, c[3:0] + 4'd9};
		end
		return r;
	endfunction

	logic [rom_image_pkg::REF_DIV_BITS-1:0] ref_div;
	logic                                   ce_ref;
	rom_image_pkg::loader_state_t           state;
	logic                                   active_q;
	rom_image_pkg::rom_page_t               page;
	logic                                   combo;

	logic                      boot_wr;
	rom_image_pkg::boot_addr_t boot_addr;
	logic [1:0]                boot_bank;
	logic [7:0]                boot_data;
	logic                      dup_bank;

	logic [10:0]              slice;
	logic                     slice_ok;
	rom_image_pkg::rom_page_t slice_page;
	logic [4:0]               ext_hi;
	logic [4:0]               ext_lo;
	rom_image_pkg::rom_page_t ext_page;
	logic                     ext_combo;

	logic accept;
	logic strobe_end;
	logic second_bank;
	logic done;

	//////////////////////////////////////////////////
	// Decoders

	assign slice = dl.addr[24:14];

	// Fixed system ROM slices of an index 0 download
	always_comb begin
		slice_ok = 1'b1;
		slice_page = rom_image_pkg::PAGE_OS;
		case (slice)
			11'd0, 11'd4: slice_page = rom_image_pkg::PAGE_OS;
			11'd1, 11'd5: slice_page = rom_image_pkg::PAGE_BASIC;
			11'd2, 11'd6: slice_page = rom_image_pkg::PAGE_AMSDOS;
			11'd3, 11'd7: slice_page = rom_image_pkg::PAGE_MF2;
			default:      slice_ok = 1'b0;
		endcase
	end

	// Expansion page from the extension characters
	always_comb begin
		ext_hi = hex_digit(dl.ext[15:8]);
		ext_lo = hex_digit(dl.ext[7:0]);
		ext_combo = 1'b0;
		if (dl.ext == "ZZ") begin
			ext_page = rom_image_pkg::PAGE_OS;
		end else if (dl.ext == "Z0") begin
			ext_page = rom_image_pkg::PAGE_OS;
			ext_combo = 1'b1;
		end else if (ext_hi[4] && ext_lo[4]) begin
			ext_page = {1'b1, ext_hi[3:0], ext_lo[3:0]};
		end else begin
			ext_page = rom_image_pkg::PAGE_BAD_EXT;
		end
	end

	assign accept = dl.active & dl.wr & ~download_wait & ((dl.index != '0) | slice_ok);
	assign strobe_end = ce_ref & (state == rom_image_pkg::strobe);
	assign second_bank = dup_bank & (boot_bank == 2'd0);
	assign done = strobe_end & ~second_bank;

	//////////////////////////////////////////////////
	// Write payload

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			boot_data <= dl.data;
			boot_addr[13:0] <= dl.addr[13:0];
			dup_bank <= (dl.index[7:6] == 2'b01) || (dl.index[5:0] != 6'd0);
			if (dl.index != '0) begin
				boot_addr[22] <= page[8];
				boot_addr[21:14] <= page[7:0] + dl.addr[21:14];
				boot_bank <= {1'b0, &dl.index[7:6]};
			end else begin
				boot_addr[22:14] <= slice_page;
				boot_bank <= {1'b0, slice[2]};
			end
		end else if (strobe_end && second_bank) begin
			boot_bank <= 2'd1;
		end
	end

	//////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ref_div <= '0;
			ce_ref <= 1'b0;
			state <= rom_image_pkg::idle;
			download_wait <= 1'b0;
			boot_wr <= 1'b0;
			active_q <= 1'b0;
			page <= rom_image_pkg::PAGE_OS;
			combo <= 1'b0;
			rom_map <= '0;
		end else begin
			ref_div <= ref_div + 1'b1;
			ce_ref <= (ref_div == '0);
			active_q <= dl.active;

			case (state)
				rom_image_pkg::idle: begin
					if (accept) begin
						state <= rom_image_pkg::pending;
						download_wait <= 1'b1;
					end
				end
				rom_image_pkg::pending: begin
					if (ce_ref) begin
						boot_wr <= 1'b1;
						state <= rom_image_pkg::strobe;
					end
				end
				rom_image_pkg::strobe: begin
					if (ce_ref) begin
						boot_wr <= 1'b0;
						if (second_bank) begin
							state <= rom_image_pkg::pending;
						end else begin
							state <= rom_image_pkg::idle;
							download_wait <= 1'b0;
						end
					end
				end
				default: state <= rom_image_pkg::idle;
			endcase

			if (strobe_end && boot_addr[22]) begin
				rom_map[boot_addr[21:14]] <= 1'b1;
			end

			// Combo image continues in the next page after its first 16K
			if (done && combo && (&boot_addr[13:0])) begin
				combo <= 1'b0;
				page <= rom_image_pkg::PAGE_COMBO_NEXT;
			end

			if (dl.active && !active_q && (dl.index != '0)) begin
				page <= ext_page;
				combo <= ext_combo;
			end
		end
	end

	assign boot = '{wr: boot_wr, addr: boot_addr, bank: boot_bank, data: boot_data};

endmodule

// File: src/rom_image_pkg.sv
package rom_image_pkg;

	//////////////////////////////////////////////////
	// Host download side

	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_addr_t;

	// ext holds the last two characters of the file extension
	typedef struct packed {
		logic      active;
		logic      wr;
		dl_index_t index;
		dl_addr_t  addr;
		logic [7:0] data;
		logic [15:0] ext;
	} download_t;

	//////////////////////////////////////////////////
	// Boot memory side

	typedef logic [22:0]  boot_addr_t;
	typedef logic [8:0]   rom_page_t;
	typedef logic [255:0] rom_map_t;

	typedef struct packed {
		logic       wr;
		boot_addr_t addr;
		logic [1:0] bank;
		logic [7:0] data;
	} boot_write_t;

	typedef enum logic [1:0] {idle, pending, strobe} loader_state_t;

	// 16K pages, bit 8 selects the expansion half
	localparam rom_page_t PAGE_OS         = 9'h000;
	localparam rom_page_t PAGE_BASIC      = 9'h100;
	localparam rom_page_t PAGE_AMSDOS     = 9'h107;
	localparam rom_page_t PAGE_MF2        = 9'h0FF;
	localparam rom_page_t PAGE_BAD_EXT    = 9'h1EE;
	localparam rom_page_t PAGE_COMBO_NEXT = 9'h1FF;

	localparam int REF_DIV_BITS = 3;

endpackage

// File: src/cpc_bus_pkg.sv
package cpc_bus_pkg;

	//////////////////////////////////////////////////
	// Z80 bus

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Bus levels seen by the expansion side
	// mem_rd and mem_wr are the memory requests
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t dout;
		logic      m1;
		logic      rd;
		logic      wr;
		logic      iorq;
		logic      mem_rd;
		logic      mem_wr;
	} cpu_bus_t;

	//////////////////////////////////////////////////
	// Multiface Two

	typedef logic [12:0] mf2_addr_t;

	typedef struct packed {
		logic disabled;
		logic hidden_at_reset;
	} mf2_cfg_t;

	localparam cpu_addr_t   MF2_NMI_VECTOR = 16'h0066;
	localparam cpu_addr_t   MF2_RET_ADDR   = 16'h0065;
	// FEE8 and FEEA share the upper 14 bits
	localparam logic [13:0] MF2_PORT_BASE  = 14'h3FBA;

	// Port high bytes of the shadowed hardware
	localparam logic [7:0] GA_PORT_HI   = 8'h7F;
	localparam logic [7:0] CRTC_SEL_HI  = 8'hBC;
	localparam logic [7:0] CRTC_DATA_HI = 8'hBD;
	localparam logic [7:0] PPI_CTRL_HI  = 8'hF7;
	localparam logic [7:0] ROM_SEL_HI   = 8'hDF;

	// Shadow locations inside the 8K RAM
	localparam mf2_addr_t SHADOW_PEN_INDEX = 13'h1FCF;
	localparam mf2_addr_t SHADOW_BORDER    = 13'h1FDF;
	localparam mf2_addr_t SHADOW_PEN_BASE  = 13'h1F90;
	localparam mf2_addr_t SHADOW_MODE      = 13'h1FEF;
	localparam mf2_addr_t SHADOW_BANKING   = 13'h1FFF;
	localparam mf2_addr_t SHADOW_CRTC_SEL  = 13'h1CFF;
	localparam mf2_addr_t SHADOW_CRTC_BASE = 13'h1DB0;
	localparam mf2_addr_t SHADOW_PPI       = 13'h17FF;
	localparam mf2_addr_t SHADOW_ROM_SEL   = 13'h1AAC;

endpackage
